//--- filelist.f
+incdir+.
dbg_pkg.sv
dbg_controller.sv
dbg_word_assembler.sv
dbg_dump_sender.sv
dbg_unit.sv
dbg_unit_asserts.sv
tb_dbg_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dbg_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_dbg_unit -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_dbg_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi

//--- tb_dbg_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_cfg.svh"

module tb_dbg_unit;

  logic               clk;
  logic               reset;
  logic               halt;
  dbg_pkg::dbg_dump_t cpu_status;
  logic               rx_done_tick;
  dbg_pkg::dbg_byte_t rx_data;
  logic               tx_done_tick = 1'b0;
  wire                tx_start;
  dbg_pkg::dbg_byte_t tx_data;
  wire                inst_wr_en;
  dbg_pkg::dbg_addr_t inst_wr_addr;
  dbg_pkg::dbg_inst_t inst_wr_data;
  wire                cpu_clk_en;
  wire                debug_prog;

  integer seed = 34511;
  int errors = 0;
  int wr_count = 0;
  int clk_en_count = 0;
  int tx_start_count = 0;
  int tx_done_count = 0;
  int tx_wait = 0;       // cycles left before the uart reports done
  int tx_delay_lo = 1;
  int tx_delay_hi = 20;

  dbg_pkg::dbg_addr_t wr_addr_log[$];
  dbg_pkg::dbg_inst_t wr_data_log[$];
  dbg_pkg::dbg_byte_t tx_log[$];

  dbg_unit u_dut (
    .clk          (clk),
    .reset        (reset),
    .halt         (halt),
    .cpu_status   (cpu_status),
    .rx_done_tick (rx_done_tick),
    .rx_data      (rx_data),
    .tx_done_tick (tx_done_tick),
    .tx_start     (tx_start),
    .tx_data      (tx_data),
    .inst_wr_en   (inst_wr_en),
    .inst_wr_addr (inst_wr_addr),
    .inst_wr_data (inst_wr_data),
    .cpu_clk_en   (cpu_clk_en),
    .debug_prog   (debug_prog)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////////////////////////
  // monitors and uart transmit model
  ////////////////////////////////////////

  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (inst_wr_en)
      begin
        wr_count++;
        wr_addr_log.push_back(inst_wr_addr);
        wr_data_log.push_back(inst_wr_data);
        $display("write addr %0d data %h", inst_wr_addr, inst_wr_data);
      end
      if (cpu_clk_en)
        clk_en_count++;
      if (tx_start)
      begin
        tx_start_count++;
        if (tx_start_count > tx_done_count + 1)
        begin
          errors++;
          $display("tx_start offered before the previous byte was done");
        end
      end
    end
  end

  // one done pulse per start, after a random delay
  always @(negedge clk)
  begin
    tx_done_tick = 1'b0;
    if (reset)
      tx_wait = 0;
    else if (tx_wait > 0)
    begin
      tx_wait--;
      if (tx_wait == 0)
      begin
        tx_done_tick = 1'b1;
        tx_done_count++;
      end
    end
    else if (tx_start)
    begin
      tx_log.push_back(tx_data);
      tx_wait = tx_delay_lo + int'($unsigned($random(seed)) % (tx_delay_hi - tx_delay_lo + 1));
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("Fail %s: expected %h, actual %h", test, expected, actual);
  endtask

  // tick stays high for two cycles, like the receiver
  task automatic send_byte(input dbg_pkg::dbg_byte_t value);
    @(negedge clk);
    rx_data      = value;
    rx_done_tick = 1'b1;
    repeat (2) @(negedge clk);
    rx_done_tick = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic wait_writes(input string test, input int target);
    int cycles;
    cycles = 0;
    while (wr_count < target && cycles < 500)
    begin
      @(posedge clk);
      cycles++;
    end
    @(negedge clk);
    if (wr_count < target)
    begin
      errors++;
      $display("%s: instruction write did not arrive in time", test);
    end
  endtask

  task automatic wait_tx_done(input string test, input int target);
    int cycles;
    cycles = 0;
    while (tx_done_count < target && cycles < 2000)
    begin
      @(posedge clk);
      cycles++;
    end
    repeat (4) @(negedge clk);  // dump_done and the mode change
    if (tx_done_count < target)
    begin
      errors++;
      $display("%s: status bytes were not all sent in time", test);
    end
  endtask

  // low byte of the status word goes out first
  task automatic check_dump(input string test, input dbg_pkg::dbg_dump_t status, input int base);
    int i;
    if (tx_log.size() != base + `DBG_DUMP_BYTES)
      report_mismatch(test, base + `DBG_DUMP_BYTES, tx_log.size());
    else
    begin
      for (i = 0; i < `DBG_DUMP_BYTES; i++)
      begin
        if (tx_log[base + i] !== status[`DBG_BYTE_W*i +: `DBG_BYTE_W])
          report_mismatch(test, status[`DBG_BYTE_W*i +: `DBG_BYTE_W], tx_log[base + i]);
      end
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_idle_ignore();
    int base;
    base = wr_count;
    send_byte(8'h07);  // not a start command
    repeat (4) @(negedge clk);
    if (wr_count != base)
      report_mismatch("idle_ignore", base, wr_count);
    if (debug_prog !== 1'b0)
      report_mismatch("idle_ignore", 0, debug_prog);
  endtask

  task automatic test_program_load();
    dbg_pkg::dbg_inst_t prog [3];
    int base;
    int w;
    int b;
    prog[0] = 32'h2008_0005;
    prog[1] = 32'h0109_4820;
    prog[2] = 32'hfc00_0000;  // top six bits set
    base = wr_count;
    send_byte(`DBG_CMD_START);
    if (debug_prog !== 1'b1)
      report_mismatch("program_load", 1, debug_prog);
    for (w = 0; w < 3; w++)
      for (b = 0; b < 4; b++)
        send_byte(prog[w][`DBG_BYTE_W*b +: `DBG_BYTE_W]);
    wait_writes("program_load", base + 3);
    repeat (4) @(negedge clk);
    if (wr_count != base + 3)
      report_mismatch("program_load", base + 3, wr_count);
    else
    begin
      for (w = 0; w < 3; w++)
      begin
        if (wr_addr_log[base + w] !== dbg_pkg::dbg_addr_t'(w))
          report_mismatch("program_load", w, wr_addr_log[base + w]);
        if (wr_data_log[base + w] !== prog[w])
          report_mismatch("program_load", prog[w], wr_data_log[base + w]);
      end
    end
    if (debug_prog !== 1'b0)
      report_mismatch("program_load", 0, debug_prog);
  endtask

  task automatic test_continuous();
    dbg_pkg::dbg_dump_t status;
    int base_tx;
    int base_done;
    int cycles;
    int en_stopped;
    status     = $random(seed);
    cpu_status = status;
    base_tx    = tx_log.size();
    base_done  = tx_done_count;
    send_byte(`DBG_CMD_CONT);
    cycles = 0;
    while (cpu_clk_en !== 1'b1 && cycles < 100)
    begin
      @(negedge clk);
      cycles++;
    end
    if (cpu_clk_en !== 1'b1)
    begin
      errors++;
      $display("continuous: cpu_clk_en never went high");
    end
    for (cycles = 0; cycles < 10; cycles++)
    begin
      @(negedge clk);
      if (cpu_clk_en !== 1'b1)
        report_mismatch("continuous", 1, cpu_clk_en);
    end
    halt = 1'b1;
    @(negedge clk);
    if (cpu_clk_en !== 1'b0)
      report_mismatch("continuous", 0, cpu_clk_en);
    en_stopped = clk_en_count;
    wait_tx_done("continuous", base_done + `DBG_DUMP_BYTES);
    check_dump("continuous", status, base_tx);
    if (clk_en_count != en_stopped)
      report_mismatch("continuous", en_stopped, clk_en_count);
    halt = 1'b0;  // unit is back in wait
  endtask

  task automatic test_step();
    dbg_pkg::dbg_dump_t status;
    int base_tx;
    int base_done;
    int en_before;
    send_byte(`DBG_CMD_STEPMODE);
    en_before = clk_en_count;
    send_byte(8'h09);  // ignored in step mode
    repeat (4) @(negedge clk);
    if (clk_en_count != en_before)
      report_mismatch("step_ignore", en_before, clk_en_count);
    status     = $random(seed);
    cpu_status = status;
    base_tx    = tx_log.size();
    base_done  = tx_done_count;
    send_byte(`DBG_CMD_STEP);
    wait_tx_done("single_step", base_done + `DBG_DUMP_BYTES);
    if (clk_en_count != en_before + 1)
      report_mismatch("single_step", en_before + 1, clk_en_count);
    check_dump("single_step", status, base_tx);
  endtask

  // slow uart, halted cpu so the dump returns to wait
  task automatic test_backpressure();
    dbg_pkg::dbg_dump_t status;
    int base_tx;
    int base_done;
    tx_delay_lo = 20;
    tx_delay_hi = 40;
    status      = $random(seed);
    cpu_status  = status;
    base_tx     = tx_log.size();
    base_done   = tx_done_count;
    halt        = 1'b1;
    send_byte(`DBG_CMD_STEP);
    wait_tx_done("backpressure", base_done + `DBG_DUMP_BYTES);
    check_dump("backpressure", status, base_tx);
    if (tx_start_count != tx_done_count)
      report_mismatch("backpressure", tx_done_count, tx_start_count);
    halt        = 1'b0;
    tx_delay_lo = 1;
    tx_delay_hi = 20;
  endtask

  task automatic test_reprogram();
    dbg_pkg::dbg_inst_t word;
    int base;
    int b;
    word = 32'hfc00_1234;
    base = wr_count;
    send_byte(`DBG_CMD_REPROG);
    send_byte(`DBG_CMD_START);
    for (b = 0; b < 4; b++)
      send_byte(word[`DBG_BYTE_W*b +: `DBG_BYTE_W]);
    wait_writes("reprogram", base + 1);
    repeat (4) @(negedge clk);
    if (wr_count != base + 1)
      report_mismatch("reprogram", base + 1, wr_count);
    else
    begin
      if (wr_addr_log[base] !== '0)
        report_mismatch("reprogram", 0, wr_addr_log[base]);
      if (wr_data_log[base] !== word)
        report_mismatch("reprogram", word, wr_data_log[base]);
    end
  endtask

  initial
  begin
    reset        = 1'b1;
    halt         = 1'b0;
    cpu_status   = '0;
    rx_done_tick = 1'b0;
    rx_data      = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    test_idle_ignore();
    test_program_load();
    test_continuous();
    test_step();
    test_backpressure();
    test_reprogram();

    repeat (4) @(negedge clk);
    $display("errors: %0d, writes: %0d, tx bytes: %0d, cpu cycles: %0d",
             errors, wr_count, tx_done_count, clk_en_count);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- dbg_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_unit_asserts (
  input wire clk,
  input wire reset,
  input wire inst_wr_en,
  input wire tx_start,
  input wire debug_prog,
  input wire cpu_clk_en
);

  ////////////////////////////////////////
  // one-cycle strobes
  ////////////////////////////////////////

  wr_single: assert property (@(posedge clk) disable iff (reset) inst_wr_en |=> !inst_wr_en)
    else $error("inst_wr_en high two cycles running");

  tx_single: assert property (@(posedge clk) disable iff (reset) tx_start |=> !tx_start)
    else $error("tx_start high two cycles running");

  // writes only while loading
  wr_in_prog: assert property (@(posedge clk) disable iff (reset) inst_wr_en |-> debug_prog)
    else $error("instruction write outside programming");

  // cpu stays stopped during a load
  no_run_in_prog: assert property (@(posedge clk) disable iff (reset)
                                   !(cpu_clk_en && debug_prog))
    else $error("cpu clock enabled during programming");

endmodule

bind dbg_unit dbg_unit_asserts u_asserts (
  .clk        (clk),
  .reset      (reset),
  .inst_wr_en (inst_wr_en),
  .tx_start   (tx_start),
  .debug_prog (debug_prog),
  .cpu_clk_en (cpu_clk_en)
);

`default_nettype wire

//--- dbg_unit.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_unit (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       halt,
  input  wire  dbg_pkg::dbg_dump_t  cpu_status,
  input  wire                       rx_done_tick,
  input  wire  dbg_pkg::dbg_byte_t  rx_data,
  input  wire                       tx_done_tick,
  output wire                       tx_start,
  output dbg_pkg::dbg_byte_t        tx_data,
  output wire                       inst_wr_en,
  output dbg_pkg::dbg_addr_t        inst_wr_addr,
  output dbg_pkg::dbg_inst_t        inst_wr_data,
  output wire                       cpu_clk_en,
  output wire                       debug_prog
);

  // controller to assembler
  wire                prog_clear;
  wire                prog_byte_valid;
  dbg_pkg::dbg_byte_t prog_byte;
  wire                prog_done;

  // controller to sender
  wire dump_start;
  wire dump_done;

  dbg_controller u_controller (
    .clk             (clk),
    .reset           (reset),
    .rx_done_tick    (rx_done_tick),
    .rx_data         (rx_data),
    .halt            (halt),
    .prog_done       (prog_done),
    .dump_done       (dump_done),
    .prog_clear      (prog_clear),
    .prog_byte_valid (prog_byte_valid),
    .prog_byte       (prog_byte),
    .debug_prog      (debug_prog),
    .cpu_clk_en      (cpu_clk_en),
    .dump_start      (dump_start)
  );

  dbg_word_assembler u_assembler (
    .clk             (clk),
    .reset           (reset),
    .prog_clear      (prog_clear),
    .prog_byte_valid (prog_byte_valid),
    .prog_byte       (prog_byte),
    .inst_wr_en      (inst_wr_en),
    .inst_wr_addr    (inst_wr_addr),
    .inst_wr_data    (inst_wr_data),
    .prog_done       (prog_done)
  );

  dbg_dump_sender u_sender (
    .clk          (clk),
    .reset        (reset),
    .dump_start   (dump_start),
    .cpu_status   (cpu_status),
    .tx_done_tick (tx_done_tick),
    .tx_start     (tx_start),
    .tx_data      (tx_data),
    .dump_done    (dump_done)
  );

endmodule

`default_nettype wire

//--- dbg_dump_sender.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_cfg.svh"

module dbg_dump_sender (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       dump_start,
  input  wire  dbg_pkg::dbg_dump_t  cpu_status,
  input  wire                       tx_done_tick,
  output logic                      tx_start,
  output dbg_pkg::dbg_byte_t        tx_data,
  output logic                      dump_done
);

  localparam dbg_pkg::dbg_dump_idx_t last_idx =
    dbg_pkg::dbg_dump_idx_t'(`DBG_DUMP_BYTES - 1);

  dbg_pkg::dbg_dump_t     status_q;   // snapshot taken at dump_start
  dbg_pkg::dbg_dump_idx_t byte_idx;   // byte currently on the line
  dbg_pkg::dbg_dump_idx_t idx_next;
  logic                   busy;
  logic                   tx_done_q;
  logic                   tx_edge;
  logic                   advance;

  assign tx_edge  = tx_done_tick & ~tx_done_q;
  assign advance  = busy & tx_edge;
  assign idx_next = byte_idx + 1'b1;

  ////////////////////////////////////////
  // handshake sequencing
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy      <= 1'b0;
      byte_idx  <= '0;
      tx_done_q <= 1'b0;
      tx_start  <= 1'b0;
      dump_done <= 1'b0;
    end
    else
    begin
      tx_done_q <= tx_done_tick;
      tx_start  <= 1'b0;
      dump_done <= 1'b0;
      if (dump_start)
      begin
        busy     <= 1'b1;
        byte_idx <= '0;
        tx_start <= 1'b1;  // low byte goes first
      end
      else if (advance)
      begin
        if (byte_idx == last_idx)
        begin
          busy      <= 1'b0;
          dump_done <= 1'b1;
        end
        else
        begin
          byte_idx <= idx_next;
          tx_start <= 1'b1;
        end
      end
    end
  end

  // payload path
  always_ff @(posedge clk)
  begin
    if (dump_start)
    begin
      status_q <= cpu_status;
      tx_data  <= cpu_status[`DBG_BYTE_W-1:0];
    end
    else if (advance && byte_idx != last_idx)
      tx_data <= status_q[idx_next*`DBG_BYTE_W +: `DBG_BYTE_W];  // held until next start
  end

endmodule

`default_nettype wire

//--- dbg_word_assembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_cfg.svh"

module dbg_word_assembler (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       prog_clear,
  input  wire                       prog_byte_valid,
  input  wire  dbg_pkg::dbg_byte_t  prog_byte,
  output logic                      inst_wr_en,
  output dbg_pkg::dbg_addr_t        inst_wr_addr,
  output dbg_pkg::dbg_inst_t        inst_wr_data,
  output logic                      prog_done
);

  localparam int inst_bytes = `DBG_INST_W / `DBG_BYTE_W;
  localparam int idx_w      = $clog2(inst_bytes);
  localparam logic [idx_w-1:0] last_byte = idx_w'(inst_bytes - 1);

  logic [idx_w-1:0]   byte_idx;
  dbg_pkg::dbg_inst_t word_next;
  logic               end_word;

  // new byte enters at the top, so the first one ends up in the low byte
  assign word_next = {prog_byte, inst_wr_data[`DBG_INST_W-1:`DBG_BYTE_W]};
  assign end_word  = &word_next[`DBG_INST_W-1 -: `DBG_END_OP_W];

  ////////////////////////////////////////
  // byte count, address and write strobe
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      inst_wr_en   <= 1'b0;
      prog_done    <= 1'b0;
      byte_idx     <= '0;
      inst_wr_addr <= '0;
    end
    else
    begin
      inst_wr_en <= 1'b0;
      prog_done  <= 1'b0;
      if (prog_clear)
      begin
        byte_idx     <= '0;
        inst_wr_addr <= '0;
      end
      else
      begin
        if (inst_wr_en)
          inst_wr_addr <= inst_wr_addr + 1'b1;  // next word slot
        if (prog_byte_valid)
        begin
          byte_idx <= byte_idx + 1'b1;  // wraps to 0 after a full word
          if (byte_idx == last_byte)
          begin
            inst_wr_en <= 1'b1;
            prog_done  <= end_word;
          end
        end
      end
    end
  end

  // shift register doubles as the write data
  always_ff @(posedge clk)
  begin
    if (prog_byte_valid)
      inst_wr_data <= word_next;
  end

endmodule

`default_nettype wire

//--- dbg_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_cfg.svh"

module dbg_controller (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       rx_done_tick,
  input  wire  dbg_pkg::dbg_byte_t  rx_data,
  input  wire                       halt,
  input  wire                       prog_done,
  input  wire                       dump_done,
  output logic                      prog_clear,
  output logic                      prog_byte_valid,
  output dbg_pkg::dbg_byte_t        prog_byte,
  output logic                      debug_prog,
  output logic                      cpu_clk_en,
  output logic                      dump_start
);

  dbg_pkg::dbg_state_t state;
  dbg_pkg::dbg_state_t state_next;

  logic rx_done_q;
  logic rx_edge;     // one cycle per received byte
  logic step_cmd;
  logic halt_stop;
  logic step_pulse;  // the single cpu cycle of a step

  ////////////////////////////////////////
  // receive edge and command qualifiers
  ////////////////////////////////////////

  assign rx_edge   = rx_done_tick & ~rx_done_q;
  assign step_cmd  = (state == dbg_pkg::st_step) & rx_edge & (rx_data == `DBG_CMD_STEP);
  assign halt_stop = (state == dbg_pkg::st_run) & halt;

  assign prog_clear      = (state == dbg_pkg::st_idle) & rx_edge
                           & (rx_data == `DBG_CMD_START);
  assign prog_byte_valid = (state == dbg_pkg::st_program) & rx_edge;
  assign prog_byte       = rx_data;  // only looked at with the strobe

  assign debug_prog = (state == dbg_pkg::st_program);
  assign cpu_clk_en = (state == dbg_pkg::st_run) | step_pulse;

  ////////////////////////////////////////
  // next mode
  ////////////////////////////////////////

  always_comb
  begin
    state_next = state;
    case (state)
      dbg_pkg::st_idle:
      begin
        if (prog_clear)
          state_next = dbg_pkg::st_program;
      end

      dbg_pkg::st_program:
      begin
        if (prog_done)  // end word just written
          state_next = dbg_pkg::st_wait;
      end

      dbg_pkg::st_wait:
      begin
        if (rx_edge)
        begin
          case (rx_data)
            `DBG_CMD_REPROG:   state_next = dbg_pkg::st_idle;
            `DBG_CMD_CONT:     state_next = dbg_pkg::st_run;
            `DBG_CMD_STEPMODE: state_next = dbg_pkg::st_step;
            default:           state_next = dbg_pkg::st_idle;
          endcase
        end
      end

      dbg_pkg::st_step:
      begin
        if (step_cmd)
          state_next = dbg_pkg::st_send;  // clock pulse and dump follow
      end

      dbg_pkg::st_run:
      begin
        if (halt)
          state_next = dbg_pkg::st_send;
      end

      dbg_pkg::st_send:
      begin
        if (dump_done)
          state_next = halt ? dbg_pkg::st_wait : dbg_pkg::st_step;
      end

      default:
        state_next = dbg_pkg::st_idle;
    endcase
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= dbg_pkg::st_idle;
      rx_done_q  <= 1'b0;
      step_pulse <= 1'b0;
      dump_start <= 1'b0;
    end
    else
    begin
      state      <= state_next;
      rx_done_q  <= rx_done_tick;
      step_pulse <= step_cmd;
      // dump right after the step cycle, or as soon as the run stops
      dump_start <= step_pulse | halt_stop;
    end
  end

endmodule

`default_nettype wire

//--- dbg_pkg.sv
`default_nettype none

`include "dbg_cfg.svh"

package dbg_pkg;

  // plain vectors for the widths used between blocks
  typedef logic [`DBG_BYTE_W-1:0] dbg_byte_t;
  typedef logic [`DBG_INST_W-1:0] dbg_inst_t;
  typedef logic [`DBG_ADDR_W-1:0] dbg_addr_t;

  // status word as seen by the host
  typedef logic [`DBG_DUMP_BYTES*`DBG_BYTE_W-1:0] dbg_dump_t;
  typedef logic [$clog2(`DBG_DUMP_BYTES)-1:0] dbg_dump_idx_t;

  // controller modes
  typedef enum logic [2:0] {
    st_idle,     // waiting for start command
    st_program,  // loading instruction memory
    st_wait,     // program loaded, waiting for a mode command
    st_step,     // one cpu cycle per step byte
    st_run,      // free running until halt
    st_send      // status dump in progress
  } dbg_state_t;

endpackage

`default_nettype wire

//--- dbg_cfg.svh
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

`define DBG_BYTE_W        8   // one uart character
`define DBG_INST_W        32  // instruction memory word
`define DBG_ADDR_W        7
`define DBG_DUMP_BYTES    4   // status word goes out in this many bytes
`define DBG_END_OP_W      6   // all-ones opcode marks the last word

////////////////////////////////////////
// command bytes from the host
////////////////////////////////////////

`define DBG_CMD_START     8'd1
`define DBG_CMD_CONT      8'd2
`define DBG_CMD_STEPMODE  8'd3
`define DBG_CMD_REPROG    8'd5
`define DBG_CMD_STEP      8'd6

`endif
